/* run.sh */
#!/bin/sh
# build with verilator, run, and judge the result from the log
verilator --binary --timing --assert -Wno-fatal --top-module rvs_exmem_tb \
	-f rvs_exmem.f -o rvs_exmem_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rvs_exmem_sim > sim.log 2>&1 || true
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

/* rvs_ex_mem_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_ex_mem_regs import rvs_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       accept_i,
	input  logic       flush_i,
	input  logic       reg_wen_i,
	input  reg_addr_t  reg_waddr_i,
	input  mem_op_e    mem_op_i,
	input  xlen_t      result_i,
	input  logic [7:0] wmask_i,
	input  xlen_t      store_data_i,
	input  logic       ebreak_i,
	output logic       reg_wen_o,
	output reg_addr_t  reg_waddr_o,
	output mem_op_e    mem_op_o,
	output xlen_t      result_o,
	output logic [7:0] wmask_o,
	output xlen_t      store_data_o,
	output logic       ebreak_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_wen_o    <= 1'b0;
			reg_waddr_o  <= '0;
			mem_op_o     <= MEM_NONE;
			result_o     <= '0;
			wmask_o      <= 8'h00;
			store_data_o <= '0;
			ebreak_o     <= 1'b0;
		end else if (flush_i) begin
			// killed instruction becomes a bubble
			reg_wen_o <= 1'b0;
			mem_op_o  <= MEM_NONE;
			wmask_o   <= 8'h00;
			ebreak_o  <= 1'b0;
		end else if (accept_i) begin
			reg_wen_o    <= reg_wen_i;
			reg_waddr_o  <= reg_waddr_i;
			mem_op_o     <= mem_op_i;
			result_o     <= result_i;
			wmask_o      <= wmask_i;
			store_data_o <= store_data_i;
			ebreak_o     <= ebreak_i;
		end else begin
			// idle or mul/div in progress, payload held
			reg_wen_o <= 1'b0;
			mem_op_o  <= MEM_NONE;
			wmask_o   <= 8'h00;
			ebreak_o  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rvs_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_ex_stage import rvs_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        valid_i,
	input  alu_op_e     alu_op_i,
	input  mem_op_e     mem_op_i,
	input  xlen_t       src1_i,
	input  xlen_t       src2_i,
	input  logic [31:0] imm_i,
	output logic        busy_o,
	output logic        accept_o,
	output xlen_t       result_o,
	output logic [7:0]  wmask_o,
	output xlen_t       store_data_o
);

	xlen_t                imm_sext;
	xlen_t                addr;
	xlen_t                alu_res;
	xlen_t                md_result;
	logic [5:0]           shamt;
	logic                 is_mem;
	logic                 is_md_op;
	logic                 is_md;
	logic                 md_start;
	logic                 md_done;
	logic                 md_expire;
	logic                 md_finish;
	logic                 md_running_q;
	logic [MD_CNT_W-1:0]  md_cycles_q;

	assign imm_sext = {{32{imm_i[31]}}, imm_i};
	assign addr     = src1_i + imm_sext; // load/store effective address
	assign shamt    = src2_i[5:0];
	assign is_mem   = (mem_op_i != MEM_NONE);

	always_comb begin
		case (alu_op_i)
			ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: is_md_op = 1'b1;
			default: is_md_op = 1'b0;
		endcase
	end

	// single-cycle alu
	always_comb begin
		case (alu_op_i)
			ALU_ADD:  alu_res = src1_i + src2_i;
			ALU_SUB:  alu_res = src1_i - src2_i;
			ALU_AND:  alu_res = src1_i & src2_i;
			ALU_OR:   alu_res = src1_i | src2_i;
			ALU_XOR:  alu_res = src1_i ^ src2_i;
			ALU_SLL:  alu_res = src1_i << shamt;
			ALU_SRL:  alu_res = src1_i >> shamt;
			ALU_SRA:  alu_res = $signed(src1_i) >>> shamt;
			ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
			ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, src1_i < src2_i};
			default:  alu_res = '0; // mul/div take the unit result
		endcase
	end

	// store byte lanes
	always_comb begin
		case (mem_op_i)
			MEM_SB:  wmask_o = 8'b0000_0001 << addr[2:0];
			MEM_SH:  wmask_o = 8'b0000_0011 << addr[2:0];
			MEM_SW:  wmask_o = 8'b0000_1111 << addr[2:0];
			MEM_SD:  wmask_o = 8'b1111_1111;
			default: wmask_o = 8'b0000_0000;
		endcase
	end

	assign store_data_o = src2_i << {addr[2:0], 3'b000};

	// mul/div handshake with the driver
	assign is_md     = valid_i && !is_mem && is_md_op;
	assign md_start  = is_md && !md_running_q;
	assign md_expire = md_running_q && (md_cycles_q == MD_CNT_W'(MULDIV_MAX - 2));
	assign md_finish = md_done || md_expire;
	assign busy_o    = is_md && !md_finish;
	assign accept_o  = valid_i && !busy_o;

	assign result_o = is_mem ? addr : (is_md_op ? md_result : alu_res);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			md_running_q <= 1'b0;
			md_cycles_q  <= '0;
		end else if (md_finish) begin
			md_running_q <= 1'b0;
		end else if (md_start) begin
			md_running_q <= 1'b1;
			md_cycles_q  <= '0;
		end else if (md_running_q) begin
			md_cycles_q <= md_cycles_q + 1'b1; // watchdog on the unit
		end
	end

	rvs_muldiv u_muldiv (
		.clk      (clk),
		.rst_n    (rst_n),
		.start_i  (md_start),
		.op_i     (alu_op_i),
		.a_i      (src1_i),
		.b_i      (src2_i),
		.done_o   (md_done),
		.result_o (md_result)
	);

endmodule

`default_nettype wire

/* rvs_exmem.f */
rvs_pkg.sv
rvs_muldiv.sv
rvs_ex_stage.sv
rvs_ex_mem_regs.sv
rvs_mem_stage.sv
rvs_exmem_top.sv
rvs_exmem_chk.sv
rvs_exmem_tb.sv

/* rvs_exmem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_exmem_chk import rvs_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic valid_i,
	input logic busy_i,
	input logic wb_valid_i,
	input logic halt_i
);

	int busy_run_q;     // consecutive cycles with busy high
	int fail_count = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			busy_run_q <= 0;
		else if (busy_i)
			busy_run_q <= busy_run_q + 1;
		else
			busy_run_q <= 0;
	end

	assert property (@(posedge clk) !rst_n |-> !wb_valid_i && !busy_i && !halt_i)
		else begin
			fail_count++;
			$error("outputs not low during reset");
		end

	assert property (@(posedge clk) disable iff (!rst_n) busy_run_q <= MULDIV_MAX)
		else begin
			fail_count++;
			$error("busy_o high longer than %0d cycles", MULDIV_MAX);
		end

	// sticky halt
	assert property (@(posedge clk) disable iff (!rst_n) !$fell(halt_i))
		else begin
			fail_count++;
			$error("halt_o fell while out of reset");
		end

	assert property (@(posedge clk) disable iff (!rst_n) busy_i |-> valid_i)
		else begin
			fail_count++;
			$error("busy_o high without valid_i");
		end

endmodule

bind rvs_exmem_top rvs_exmem_chk u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.valid_i    (valid_i),
	.busy_i     (busy_o),
	.wb_valid_i (wb_valid_o),
	.halt_i     (halt_o)
);

`default_nettype wire

/* rvs_exmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_exmem_tb import rvs_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        valid;
	alu_op_e     alu_op;
	mem_op_e     mem_op;
	xlen_t       src1;
	xlen_t       src2;
	logic [31:0] imm;
	logic        reg_wen;
	reg_addr_t   reg_waddr;
	logic        ebreak;
	logic        flush;
	logic        busy;
	logic        wb_valid;
	reg_addr_t   wb_waddr;
	xlen_t       wb_data;
	logic        halt;

	integer      seed = 32'h963c2f35;
	int          errors = 0;   // wrong values
	int          failures = 0; // timeouts, missing or extra write-backs
	int          assert_fails;
	logic [7:0]  shadow [0:2047]; // byte view of the data memory

	rvs_exmem_top uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid_i     (valid),
		.alu_op_i    (alu_op),
		.mem_op_i    (mem_op),
		.src1_i      (src1),
		.src2_i      (src2),
		.imm_i       (imm),
		.reg_wen_i   (reg_wen),
		.reg_waddr_i (reg_waddr),
		.ebreak_i    (ebreak),
		.flush_i     (flush),
		.busy_o      (busy),
		.wb_valid_o  (wb_valid),
		.wb_waddr_o  (wb_waddr),
		.wb_data_o   (wb_data),
		.halt_o      (halt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic xlen_t rand64();
		rand64 = {$random(seed), $random(seed)};
	endfunction

	// riscv semantics, division corner cases included
	function automatic xlen_t ref_result(input alu_op_e op, input xlen_t a, input xlen_t b);
		logic signed [XLEN-1:0] sa;
		logic signed [XLEN-1:0] sb;
		logic                   ovf;
		sa  = a;
		sb  = b;
		ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
		case (op)
			ALU_ADD:  ref_result = a + b;
			ALU_SUB:  ref_result = a - b;
			ALU_AND:  ref_result = a & b;
			ALU_OR:   ref_result = a | b;
			ALU_XOR:  ref_result = a ^ b;
			ALU_SLL:  ref_result = a << b[5:0];
			ALU_SRL:  ref_result = a >> b[5:0];
			ALU_SRA:  ref_result = sa >>> b[5:0];
			ALU_SLT:  ref_result = (sa < sb) ? 64'd1 : 64'd0;
			ALU_SLTU: ref_result = (a < b) ? 64'd1 : 64'd0;
			ALU_MUL:  ref_result = a * b;
			ALU_DIV: begin
				if (b == '0)
					ref_result = '1;
				else if (ovf)
					ref_result = a;
				else
					ref_result = sa / sb;
			end
			ALU_REM: begin
				if (b == '0)
					ref_result = a;
				else if (ovf)
					ref_result = '0;
				else
					ref_result = sa % sb;
			end
			ALU_DIVU: ref_result = (b == '0) ? '1 : a / b;
			default:  ref_result = (b == '0) ? a : a % b; // remu
		endcase
	endfunction

	function automatic int size_of(input mem_op_e op);
		case (op)
			MEM_LB, MEM_LBU, MEM_SB: size_of = 1;
			MEM_LH, MEM_LHU, MEM_SH: size_of = 2;
			MEM_LW, MEM_LWU, MEM_SW: size_of = 4;
			default:                 size_of = 8;
		endcase
	endfunction

	function automatic xlen_t load_model(input mem_op_e op, input int unsigned addr);
		xlen_t raw;
		raw = '0;
		for (int k = 0; k < size_of(op); k++)
			raw[k*8 +: 8] = shadow[addr + k]; // little endian
		case (op)
			MEM_LB:  load_model = {{56{raw[7]}}, raw[7:0]};
			MEM_LH:  load_model = {{48{raw[15]}}, raw[15:0]};
			MEM_LW:  load_model = {{32{raw[31]}}, raw[31:0]};
			default: load_model = raw; // zero extended already
		endcase
	endfunction

	task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			errors++;
			$display("error %s: expected x%0d, actual x%0d", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic present(input alu_op_e op, input mem_op_e mop, input xlen_t a, input xlen_t b,
			input logic [31:0] im, input logic wen, input reg_addr_t wa, input logic brk,
			input logic fl);
		valid     = 1'b1;
		alu_op    = op;
		mem_op    = mop;
		src1      = a;
		src2      = b;
		imm       = im;
		reg_wen   = wen;
		reg_waddr = wa;
		ebreak    = brk;
		flush     = fl;
	endtask

	task automatic go_idle();
		valid     = 1'b0;
		alu_op    = ALU_ADD;
		mem_op    = MEM_NONE;
		src1      = '0;
		src2      = '0;
		imm       = '0;
		reg_wen   = 1'b0;
		reg_waddr = '0;
		ebreak    = 1'b0;
		flush     = 1'b0;
	endtask

	// waits out busy, returns 2 ns after the accepting edge
	task automatic accept(input string name);
		int n;
		n = 0;
		#1;
		while (busy && n < MULDIV_MAX + 4) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (busy) begin
			failures++;
			$display("%s: busy_o did not fall within %0d cycles", name, n);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic wait_wb(input string name, input int limit);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#2;
			n++;
		end while (!wb_valid && n < limit);
		if (!wb_valid) begin
			failures++;
			$display("%s: no write-back within %0d edges of acceptance", name, limit);
		end
	endtask

	task automatic check_wb(input string name, input reg_addr_t wa, input xlen_t exp);
		check_addr(name, wa, wb_waddr);
		check_data(name, exp, wb_data);
	endtask

	task automatic expect_quiet(input string name, input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
			check_bit({name, " no write-back"}, 1'b0, wb_valid);
		end
	endtask

	task automatic do_alu(input string name, input alu_op_e op, input xlen_t a, input xlen_t b,
			input reg_addr_t wa);
		present(op, MEM_NONE, a, b, 32'd0, 1'b1, wa, 1'b0, 1'b0);
		accept(name);
		go_idle();
		wait_wb(name, 1);
		check_wb(name, wa, ref_result(op, a, b));
	endtask

	// random imm, src1 chosen so the sum hits addr
	task automatic present_mem(input mem_op_e mop, input int unsigned addr, input xlen_t data,
			input logic wen, input reg_addr_t wa, input logic fl);
		logic [31:0] im;
		im = $random(seed);
		im = {{20{im[11]}}, im[11:0]};
		present(ALU_SUB, mop, xlen_t'(addr) - {{32{im[31]}}, im}, data, im, wen, wa, 1'b0, fl);
	endtask

	task automatic do_store(input string name, input mem_op_e mop, input int unsigned addr,
			input xlen_t data, input logic fl);
		present_mem(mop, addr, data, 1'b1, 5'd31, fl); // wen set, store must not write back
		accept(name);
		go_idle();
		expect_quiet(name, 2);
		if (!fl) begin
			for (int k = 0; k < size_of(mop); k++)
				shadow[addr + k] = data[k*8 +: 8];
		end
	endtask

	task automatic do_load(input string name, input mem_op_e mop, input int unsigned addr,
			input reg_addr_t wa);
		present_mem(mop, addr, '0, 1'b1, wa, 1'b0);
		accept(name);
		go_idle();
		wait_wb(name, 1);
		check_wb(name, wa, load_model(mop, addr));
	endtask

	task automatic run_md(input string name, input alu_op_e op, input xlen_t a, input xlen_t b,
			input logic follow);
		xlen_t fa;
		xlen_t fb;
		fa = rand64();
		fb = rand64();
		present(op, MEM_NONE, a, b, 32'd0, 1'b1, 5'd20, 1'b0, 1'b0);
		#1;
		check_bit({name, " busy"}, 1'b1, busy);
		accept(name);
		if (follow)
			present(ALU_SUB, MEM_NONE, fa, fb, 32'd0, 1'b1, 5'd21, 1'b0, 1'b0);
		else
			go_idle();
		wait_wb(name, 1);
		go_idle();
		check_wb(name, 5'd20, ref_result(op, a, b));
		if (follow) begin
			wait_wb({name, " follow"}, 1);
			check_wb({name, " follow"}, 5'd21, fa - fb);
		end
	endtask

	task automatic test_reset();
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		check_bit("reset wb_valid", 1'b0, wb_valid);
		check_bit("reset busy", 1'b0, busy);
		check_bit("reset halt", 1'b0, halt);
	endtask

	// one instruction per cycle, each result due two edges later
	task automatic test_alu_b2b();
		alu_op_e     ops [12];
		xlen_t       exp_q [12];
		int unsigned r;
		xlen_t       a;
		xlen_t       b;
		for (int i = 0; i < 14; i++) begin
			if (i >= 2) begin
				check_bit($sformatf("alu %0d valid", i - 2), 1'b1, wb_valid);
				check_wb($sformatf("alu %0d %s", i - 2, ops[i - 2].name()),
					reg_addr_t'(i - 1), exp_q[i - 2]);
			end
			if (i < 12) begin
				r = $random(seed);
				ops[i] = alu_op_e'(4'(r % 10));
				a = rand64();
				b = rand64();
				exp_q[i] = ref_result(ops[i], a, b);
				present(ops[i], MEM_NONE, a, b, 32'd0, 1'b1, reg_addr_t'(i + 1), 1'b0, 1'b0);
			end else begin
				go_idle();
			end
			@(posedge clk);
			#2;
		end
	endtask

	task automatic test_mem();
		int unsigned r;
		int unsigned base;
		for (int t = 0; t < 4; t++) begin
			r = $random(seed);
			base = (r % DMEM_DEPTH) * 8;
			do_store("sd", MEM_SD, base, rand64(), 1'b0); // whole dword known first
			do_store("sw", MEM_SW, base + 4 * r[9], rand64(), 1'b0);
			do_store("sh", MEM_SH, base + 2 * r[11:10], rand64(), 1'b0);
			do_store("sb", MEM_SB, base + r[14:12], rand64(), 1'b0);
			r = $random(seed);
			do_load("lb", MEM_LB, base + r[2:0], 5'd1);
			do_load("lbu", MEM_LBU, base + r[5:3], 5'd2);
			do_load("lh", MEM_LH, base + 2 * r[7:6], 5'd3);
			do_load("lhu", MEM_LHU, base + 2 * r[9:8], 5'd4);
			do_load("lw", MEM_LW, base + 4 * r[10], 5'd5);
			do_load("lwu", MEM_LWU, base + 4 * r[11], 5'd6);
			do_load("ld", MEM_LD, base, 5'd7);
		end
	endtask

	task automatic test_muldiv();
		xlen_t min_int;
		min_int = {1'b1, {(XLEN-1){1'b0}}};
		run_md("mul", ALU_MUL, rand64(), rand64(), 1'b1);
		run_md("div", ALU_DIV, rand64(), xlen_t'($random(seed)), 1'b1);
		run_md("divu", ALU_DIVU, rand64(), xlen_t'($random(seed)), 1'b0);
		run_md("rem", ALU_REM, rand64(), xlen_t'($random(seed)), 1'b0);
		run_md("remu", ALU_REMU, rand64(), xlen_t'($random(seed)), 1'b0);
		run_md("div wide", ALU_DIV, rand64(), rand64(), 1'b0);
		run_md("div by zero", ALU_DIV, rand64(), '0, 1'b1);
		run_md("divu by zero", ALU_DIVU, rand64(), '0, 1'b0);
		run_md("rem by zero", ALU_REM, rand64(), '0, 1'b0);
		run_md("remu by zero", ALU_REMU, rand64(), '0, 1'b1);
		run_md("div overflow", ALU_DIV, min_int, '1, 1'b0);
		run_md("rem overflow", ALU_REM, min_int, '1, 1'b0);
	endtask

	task automatic test_flush();
		int unsigned addr;
		addr = ($random(seed) & 255) * 8;
		do_store("flush setup sd", MEM_SD, addr, rand64(), 1'b0);
		do_store("flushed sd", MEM_SD, addr, rand64(), 1'b1);
		do_load("ld after flush", MEM_LD, addr, 5'd9);
		present(ALU_ADD, MEM_NONE, rand64(), rand64(), 32'd0, 1'b1, 5'd10, 1'b0, 1'b1);
		accept("flushed add");
		go_idle();
		expect_quiet("flushed add", 3);
		do_alu("or after flush", ALU_OR, rand64(), rand64(), 5'd11);
	endtask

	task automatic test_halt();
		int n;
		check_bit("halt before ebreak", 1'b0, halt);
		present(ALU_ADD, MEM_NONE, '0, '0, 32'd0, 1'b0, 5'd0, 1'b1, 1'b0);
		accept("ebreak");
		go_idle();
		n = 0;
		while (!halt && n < 4) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!halt) begin
			failures++;
			$display("ebreak: halt_o did not rise within 4 cycles");
		end
		do_alu("sll after halt", ALU_SLL, rand64(), rand64(), 5'd12);
		check_bit("halt held after alu", 1'b1, halt);
		do_store("sd after halt", MEM_SD, 64, rand64(), 1'b0);
		do_load("lw after halt", MEM_LW, 68, 5'd13);
		check_bit("halt held after load", 1'b1, halt);
	endtask

	initial begin
		go_idle();
		rst_n = 1'b0;
		test_reset();
		test_alu_b2b();
		test_mem();
		test_muldiv();
		test_flush();
		test_halt();
		assert_fails = uut.u_chk.fail_count;
		$display("%0d value errors, %0d other failures, %0d assertion failures",
			errors, failures, assert_fails);
		if (errors == 0 && failures == 0 && assert_fails == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rvs_exmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_exmem_top import rvs_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        valid_i,
	input  alu_op_e     alu_op_i,
	input  mem_op_e     mem_op_i,
	input  xlen_t       src1_i,
	input  xlen_t       src2_i,
	input  logic [31:0] imm_i,
	input  logic        reg_wen_i,
	input  reg_addr_t   reg_waddr_i,
	input  logic        ebreak_i,
	input  logic        flush_i,
	output logic        busy_o,
	output logic        wb_valid_o,
	output reg_addr_t   wb_waddr_o,
	output xlen_t       wb_data_o,
	output logic        halt_o
);

	// execute stage outputs
	logic       ex_accept;
	xlen_t      ex_result;
	logic [7:0] ex_wmask;
	xlen_t      ex_store_data;

	// ex/mem register outputs
	logic       mr_reg_wen;
	reg_addr_t  mr_reg_waddr;
	mem_op_e    mr_mem_op;
	xlen_t      mr_result;
	logic [7:0] mr_wmask;
	xlen_t      mr_store_data;
	logic       mr_ebreak;

	rvs_ex_stage u_ex (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid_i      (valid_i),
		.alu_op_i     (alu_op_i),
		.mem_op_i     (mem_op_i),
		.src1_i       (src1_i),
		.src2_i       (src2_i),
		.imm_i        (imm_i),
		.busy_o       (busy_o),
		.accept_o     (ex_accept),
		.result_o     (ex_result),
		.wmask_o      (ex_wmask),
		.store_data_o (ex_store_data)
	);

	rvs_ex_mem_regs u_ex_mem (
		.clk          (clk),
		.rst_n        (rst_n),
		.accept_i     (ex_accept),
		.flush_i      (flush_i),
		.reg_wen_i    (reg_wen_i),
		.reg_waddr_i  (reg_waddr_i),
		.mem_op_i     (mem_op_i),
		.result_i     (ex_result),
		.wmask_i      (ex_wmask),
		.store_data_i (ex_store_data),
		.ebreak_i     (ebreak_i),
		.reg_wen_o    (mr_reg_wen),
		.reg_waddr_o  (mr_reg_waddr),
		.mem_op_o     (mr_mem_op),
		.result_o     (mr_result),
		.wmask_o      (mr_wmask),
		.store_data_o (mr_store_data),
		.ebreak_o     (mr_ebreak)
	);

	rvs_mem_stage u_mem (
		.clk          (clk),
		.rst_n        (rst_n),
		.reg_wen_i    (mr_reg_wen),
		.reg_waddr_i  (mr_reg_waddr),
		.mem_op_i     (mr_mem_op),
		.result_i     (mr_result),
		.wmask_i      (mr_wmask),
		.store_data_i (mr_store_data),
		.ebreak_i     (mr_ebreak),
		.wb_valid_o   (wb_valid_o),
		.wb_waddr_o   (wb_waddr_o),
		.wb_data_o    (wb_data_o),
		.halt_o       (halt_o)
	);

endmodule

`default_nettype wire

/* rvs_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_mem_stage import rvs_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       reg_wen_i,
	input  reg_addr_t  reg_waddr_i,
	input  mem_op_e    mem_op_i,
	input  xlen_t      result_i,
	input  logic [7:0] wmask_i,
	input  xlen_t      store_data_i,
	input  logic       ebreak_i,
	output logic       wb_valid_o,
	output reg_addr_t  wb_waddr_o,
	output xlen_t      wb_data_o,
	output logic       halt_o
);

	xlen_t              mem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] idx;
	xlen_t              rdata;
	xlen_t              lane;
	xlen_t              load_data;
	logic               is_load;
	logic               is_store;

	assign idx = result_i[DMEM_AW+2:3]; // doubleword index

	always_comb begin
		is_load  = 1'b0;
		is_store = 1'b0;
		case (mem_op_i)
			MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU: is_load = 1'b1;
			MEM_SB, MEM_SH, MEM_SW, MEM_SD: is_store = 1'b1;
			default: ;
		endcase
	end

	// byte-masked store
	always_ff @(posedge clk) begin
		if (is_store) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask_i[b])
					mem[idx][b*8 +: 8] <= store_data_i[b*8 +: 8];
			end
		end
	end

	assign rdata = mem[idx];
	assign lane  = rdata >> {result_i[2:0], 3'b000}; // addressed byte to bit 0

	always_comb begin
		case (mem_op_i)
			MEM_LB:  load_data = {{56{lane[7]}}, lane[7:0]};
			MEM_LH:  load_data = {{48{lane[15]}}, lane[15:0]};
			MEM_LW:  load_data = {{32{lane[31]}}, lane[31:0]};
			MEM_LBU: load_data = {56'd0, lane[7:0]};
			MEM_LHU: load_data = {48'd0, lane[15:0]};
			MEM_LWU: load_data = {32'd0, lane[31:0]};
			default: load_data = lane; // ld
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o <= 1'b0;
			wb_waddr_o <= '0;
			wb_data_o  <= '0;
			halt_o     <= 1'b0;
		end else begin
			wb_valid_o <= reg_wen_i && !is_store;
			wb_waddr_o <= reg_waddr_i;
			wb_data_o  <= is_load ? load_data : result_i;
			if (ebreak_i)
				halt_o <= 1'b1; // sticky until reset
		end
	end

endmodule

`default_nettype wire

/* rvs_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module rvs_muldiv import rvs_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start_i,
	input  alu_op_e op_i,
	input  xlen_t   a_i,
	input  xlen_t   b_i,
	output logic    done_o,
	output xlen_t   result_o
);

	md_state_e       state_q;
	logic [5:0]      cnt_q;
	alu_op_e         op_q;
	xlen_t           quo_q;   // multiplier, then quotient
	xlen_t           dvs_q;   // multiplicand or divisor
	xlen_t           acc_q;   // product or partial remainder
	logic            neg_quo_q;
	logic            neg_rem_q;
	logic            is_mul;
	logic            is_signed;
	logic            div_zero;
	xlen_t           abs_a;
	xlen_t           abs_b;
	logic [XLEN:0]   trial;

	assign is_mul    = (op_i == ALU_MUL);
	assign is_signed = (op_i == ALU_DIV) || (op_i == ALU_REM);
	assign div_zero  = !is_mul && (b_i == '0);
	assign abs_a     = (is_signed && a_i[XLEN-1]) ? -a_i : a_i;
	assign abs_b     = (is_signed && b_i[XLEN-1]) ? -b_i : b_i;

	// restoring step, borrow out in the top bit
	assign trial = {acc_q, quo_q[XLEN-1]} - {1'b0, dvs_q};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= MD_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				MD_IDLE: begin
					if (start_i) begin
						state_q <= div_zero ? MD_DONE : MD_RUN; // x/0 needs no steps
						cnt_q   <= '0;
					end
				end
				MD_RUN: begin
					cnt_q <= cnt_q + 6'd1;
					if (cnt_q == 6'(XLEN - 1))
						state_q <= MD_DONE;
				end
				default: state_q <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == MD_IDLE && start_i) begin
			op_q <= op_i;
			if (div_zero) begin
				quo_q     <= '1;   // quotient all ones
				acc_q     <= a_i;  // remainder is the dividend
				dvs_q     <= b_i;
				neg_quo_q <= 1'b0;
				neg_rem_q <= 1'b0;
			end else begin
				quo_q     <= is_mul ? b_i : abs_a;
				dvs_q     <= is_mul ? a_i : abs_b;
				acc_q     <= '0;
				neg_quo_q <= is_signed && (a_i[XLEN-1] ^ b_i[XLEN-1]);
				neg_rem_q <= is_signed && a_i[XLEN-1];
			end
		end else if (state_q == MD_RUN) begin
			if (op_q == ALU_MUL) begin
				if (quo_q[0])
					acc_q <= acc_q + dvs_q;
				quo_q <= quo_q >> 1;
				dvs_q <= dvs_q << 1;
			end else if (!trial[XLEN]) begin
				acc_q <= trial[XLEN-1:0];
				quo_q <= {quo_q[XLEN-2:0], 1'b1};
			end else begin
				acc_q <= {acc_q[XLEN-2:0], quo_q[XLEN-1]};
				quo_q <= {quo_q[XLEN-2:0], 1'b0};
			end
		end
	end

	assign done_o = (state_q == MD_DONE);

	// sign fix-up, stable until the next start
	always_comb begin
		case (op_q)
			ALU_MUL:           result_o = acc_q;
			ALU_DIV, ALU_DIVU: result_o = neg_quo_q ? -quo_q : quo_q;
			default:           result_o = neg_rem_q ? -acc_q : acc_q;
		endcase
	end

endmodule

`default_nettype wire

/* rvs_pkg.sv */
`default_nettype none

package rvs_pkg;

	// datapath
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// data memory, doubleword organised
	localparam int DMEM_DEPTH = 256;
	localparam int DMEM_AW    = 8; // doubleword index width, 2 KiB of bytes

	// longest time busy may stay high for one mul/div
	localparam int MULDIV_MAX = 70;
	localparam int MD_CNT_W   = $clog2(MULDIV_MAX + 1);

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_MUL,   // multi-cycle from here on
		ALU_DIV,
		ALU_DIVU,
		ALU_REM,
		ALU_REMU
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LD,
		MEM_LBU,
		MEM_LHU,
		MEM_LWU,
		MEM_SB,
		MEM_SH,
		MEM_SW,
		MEM_SD
	} mem_op_e;

	// mul/div sequencer
	typedef enum logic [1:0] {
		MD_IDLE,
		MD_RUN,
		MD_DONE
	} md_state_e;

endpackage

`default_nettype wire
